// ==== logic/rbk_cfg.svh ====
/*
 * width and step constants for the reshape request generator.
 * included by both packages and by modules that size logic from them
 */
`ifndef RBK_CFG_SVH
`define RBK_CFG_SVH

// atom address, 32-byte units
`define RBK_ADDR_W 59
`define RBK_DIM_W 13
`define RBK_STRIDE_W 27
// atom to byte address
`define RBK_ATOM_SHIFT 5

// width chunking
`define RBK_CHUNK_ELEMS 64
`define RBK_PACKED_STEP 64
// channel group counting unit
`define RBK_CHN_UNIT 16

`define RBK_PERF_W 32

`endif

// ==== logic/rbk_geom_pkg.sv ====
/*
 * geometry types for the reshape engine: addresses, dimensions,
 * strides, loop counters and the mode and precision encodings
 */
`include "rbk_cfg.svh"

package rbk_geom_pkg;

  typedef logic [`RBK_ADDR_W-1:0] rbk_addr_t;
  // register value, one less than the element count
  typedef logic [`RBK_DIM_W-1:0] rbk_dim_t;
  typedef logic [`RBK_STRIDE_W-1:0] rbk_stride_t;
  typedef logic [`RBK_DIM_W-1:0] rbk_cnt_t;

  // only split and merge are supported
  typedef enum logic [1:0] {
    RBK_SPLIT = 2'd1,
    RBK_MERGE = 2'd2
  } rbk_mode_e;

  typedef enum logic [1:0] {
    RBK_INT8  = 2'd0,
    RBK_INT16 = 2'd1
  } rbk_prec_e;

endpackage

// ==== logic/rbk_cmd_pkg.sv ====
/*
 * payload types for the DMA requests and the buffer commands
 * driven by the reshape request generator
 */
`include "rbk_cfg.svh"

package rbk_cmd_pkg;

  // burst size minus one, 32-byte units
  typedef logic [`RBK_DIM_W-1:0] rbk_size_t;

  typedef struct packed {
    logic [4:0] row;
    logic [5:0] col;
  } rbk_rf_cmd_t;

  typedef struct packed {
    logic [`RBK_DIM_W+1:0] size;
    logic [`RBK_ADDR_W+`RBK_ATOM_SHIFT-1:0] addr;
  } rbk_rd_pd_t;

  typedef struct packed {
    logic done;
    rbk_size_t size;
    logic [`RBK_ADDR_W+`RBK_ATOM_SHIFT-1:0] addr;
  } rbk_wr_pd_t;

endpackage

// ==== logic/rbk_walk_cfg_if.sv ====
/*
 * launch settings of one request stream, driven by the launch
 * block and read by an address walker
 */
`timescale 1ns/100ps

interface rbk_walk_cfg_if;
  import rbk_geom_pkg::*;

  rbk_addr_t base;
  rbk_stride_t line_stride;
  rbk_stride_t surf_stride;
  rbk_stride_t planar_stride;
  // layout select, high for planar
  logic planar;
  logic byte_data;
  rbk_dim_t width;
  rbk_dim_t height;
  rbk_dim_t channel;
  logic start;
  logic run;

  modport launch (
    output base, line_stride, surf_stride, planar_stride, planar, byte_data,
    output width, height, channel, start, run
  );

  modport walker (
    input base, line_stride, surf_stride, planar_stride, planar, byte_data,
    input width, height, channel, start, run
  );

endinterface

// ==== logic/rbk_launch.sv ====
/*
 * operation launch: samples mode and precision, keeps the run level
 * between op_en and dp2reg_done, and fills the read and write walker settings
 */
`timescale 1ns/100ps
`include "rbk_cfg.svh"

module rbk_launch (
  input  logic nvdla_core_clk,
  input  logic nvdla_core_rstn,
  input  logic op_en,
  input  logic dp2reg_done,
  input  rbk_geom_pkg::rbk_mode_e mode,
  input  rbk_geom_pkg::rbk_prec_e precision,
  input  logic [`RBK_ADDR_W-`RBK_STRIDE_W-1:0] dain_addr_high,
  input  rbk_geom_pkg::rbk_stride_t dain_addr_low,
  input  rbk_geom_pkg::rbk_stride_t dain_line_stride,
  input  rbk_geom_pkg::rbk_stride_t dain_planar_stride,
  input  rbk_geom_pkg::rbk_stride_t dain_surf_stride,
  input  rbk_geom_pkg::rbk_dim_t datain_width,
  input  rbk_geom_pkg::rbk_dim_t datain_height,
  input  rbk_geom_pkg::rbk_dim_t datain_channel,
  input  logic [`RBK_ADDR_W-`RBK_STRIDE_W-1:0] daout_addr_high,
  input  rbk_geom_pkg::rbk_stride_t daout_addr_low,
  input  rbk_geom_pkg::rbk_stride_t daout_line_stride,
  input  rbk_geom_pkg::rbk_stride_t daout_planar_stride,
  input  rbk_geom_pkg::rbk_stride_t daout_surf_stride,
  input  rbk_geom_pkg::rbk_dim_t dataout_channel,
  rbk_walk_cfg_if.launch rd_cfg,
  rbk_walk_cfg_if.launch wr_cfg
);
  import rbk_geom_pkg::*;

  rbk_mode_e mode_q;
  rbk_prec_e prec_q;
  logic run;
  logic run_d;
  logic start;

  ////////////////////
  // config sample
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      mode_q <= RBK_SPLIT;
      prec_q <= RBK_INT8;
    end else begin
      mode_q <= mode;
      prec_q <= precision;
    end
  end

  ////////////////////
  // run level and start pulse
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      run   <= 1'b0;
      run_d <= 1'b0;
      start <= 1'b0;
    end else begin
      if (dp2reg_done) begin
        run <= 1'b0;
      end else if (op_en) begin
        run <= 1'b1;
      end
      run_d <= run;
      // one cycle after run rises
      start <= run & ~run_d;
    end
  end

  // read side walks the input cube
  assign rd_cfg.base          = {dain_addr_high, dain_addr_low};
  assign rd_cfg.line_stride   = dain_line_stride;
  assign rd_cfg.surf_stride   = dain_surf_stride;
  assign rd_cfg.planar_stride = dain_planar_stride;
  assign rd_cfg.planar        = (mode_q == RBK_MERGE);
  assign rd_cfg.byte_data     = (prec_q == RBK_INT8);
  assign rd_cfg.width         = datain_width;
  assign rd_cfg.height        = datain_height;
  assign rd_cfg.channel       = datain_channel;
  assign rd_cfg.start         = start;
  assign rd_cfg.run           = run;

  // write side, same width and height
  assign wr_cfg.base          = {daout_addr_high, daout_addr_low};
  assign wr_cfg.line_stride   = daout_line_stride;
  assign wr_cfg.surf_stride   = daout_surf_stride;
  assign wr_cfg.planar_stride = daout_planar_stride;
  assign wr_cfg.planar        = (mode_q == RBK_SPLIT);
  assign wr_cfg.byte_data     = (prec_q == RBK_INT8);
  assign wr_cfg.width         = datain_width;
  assign wr_cfg.height        = datain_height;
  assign wr_cfg.channel       = dataout_channel;
  assign wr_cfg.start         = start;
  assign wr_cfg.run           = run;

  // the mode seen by both walkers must be one the walkers understand
  a_mode_supported : assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    op_en |=> (mode_q == RBK_SPLIT) || (mode_q == RBK_MERGE)
  ) else $error("op_en with unsupported reshape mode");

endmodule

// ==== logic/rbk_addr_walker.sv ====
/*
 * address walker for one request stream. steps groups, lines, width
 * chunks and, in planar layout, planes, and issues one burst per step
 */
`timescale 1ns/100ps
`include "rbk_cfg.svh"

module rbk_addr_walker (
  input  logic nvdla_core_clk,
  input  logic nvdla_core_rstn,
  rbk_walk_cfg_if.walker cfg,
  input  logic dp2reg_done,
  input  logic buf_rdy,
  input  logic req_rdy,
  output logic req_vld,
  output rbk_geom_pkg::rbk_addr_t req_addr,
  output rbk_cmd_pkg::rbk_size_t req_size,
  output logic req_last,
  output logic rf_cmd_vld,
  output rbk_cmd_pkg::rbk_rf_cmd_t rf_cmd
);
  import rbk_geom_pkg::*;
  import rbk_cmd_pkg::*;

  localparam rbk_cnt_t CNT_ONE = 1;

  rbk_cnt_t plane_cnt;
  rbk_cnt_t chunk_cnt;
  rbk_cnt_t line_cnt;
  rbk_cnt_t grp_cnt;
  rbk_addr_t cur_addr;
  rbk_addr_t chunk_base;
  rbk_addr_t line_base;
  rbk_addr_t grp_base;
  logic pend;
  logic done_hold;

  rbk_dim_t rem_w;
  rbk_dim_t rem_c;
  logic [5:0] elem_m1;
  logic [5:0] pln_size;
  logic [5:0] size_col;
  logic [4:0] grp_max;
  logic [4:0] planes_m1;
  rbk_cnt_t grp_inc;
  logic chunk_last;
  logic grp_last;
  logic line_last;
  logic plane_last;
  logic acc;
  logic plane_end;
  logic row_done;
  logic grp_done;
  logic all_done;
  rbk_addr_t grp_step;
  rbk_addr_t chunk_step;

  ////////////////////
  // remaining width and channels
  assign rem_w = cfg.width - rbk_dim_t'(chunk_cnt * `RBK_CHUNK_ELEMS);
  assign rem_c = cfg.channel - rbk_dim_t'(grp_cnt * `RBK_CHN_UNIT);

  assign chunk_last = rem_w < `RBK_CHUNK_ELEMS;
  assign elem_m1    = chunk_last ? rem_w[5:0] : 6'(`RBK_CHUNK_ELEMS - 1);

  // planar burst covers one chunk of a single plane
  assign pln_size = cfg.byte_data ? (elem_m1 >> 5) : (elem_m1 >> 4);
  assign size_col = cfg.planar ? pln_size : elem_m1;

  // 32 channels per group at int8, 16 at int16
  assign grp_max   = cfg.byte_data ? 5'd31 : 5'd15;
  assign grp_inc   = cfg.byte_data ? rbk_cnt_t'(2) : rbk_cnt_t'(1);
  assign grp_last  = rem_c <= rbk_dim_t'(grp_max);
  assign planes_m1 = grp_last ? rem_c[4:0] : grp_max;

  assign line_last  = (line_cnt == cfg.height);
  assign plane_last = ~cfg.planar | (plane_cnt == rbk_cnt_t'(planes_m1));

  ////////////////////
  // loop events
  assign acc       = req_vld & req_rdy;
  assign plane_end = acc & plane_last;
  assign row_done  = plane_end & chunk_last;
  assign grp_done  = row_done & line_last;
  assign all_done  = grp_done & grp_last;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      plane_cnt <= '0;
      chunk_cnt <= '0;
      line_cnt  <= '0;
      grp_cnt   <= '0;
    end else if (cfg.start) begin
      plane_cnt <= '0;
      chunk_cnt <= '0;
      line_cnt  <= '0;
      grp_cnt   <= '0;
    end else if (acc) begin
      plane_cnt <= plane_end ? '0 : plane_cnt + CNT_ONE;
      if (plane_end) begin
        chunk_cnt <= row_done ? '0 : chunk_cnt + CNT_ONE;
      end
      if (row_done) begin
        line_cnt <= grp_done ? '0 : line_cnt + CNT_ONE;
      end
      if (grp_done) begin
        grp_cnt <= all_done ? '0 : grp_cnt + grp_inc;
      end
    end
  end

  ////////////////////
  // address bases
  // packed groups step by surface, planar groups by G planes
  assign grp_step = cfg.planar ?
                    (rbk_addr_t'(cfg.planar_stride) << (cfg.byte_data ? 5 : 4)) :
                    rbk_addr_t'(cfg.surf_stride);
  assign chunk_step = cfg.planar ? (cfg.byte_data ? rbk_addr_t'(2) : rbk_addr_t'(4)) :
                      rbk_addr_t'(`RBK_PACKED_STEP);

  always_ff @(posedge nvdla_core_clk) begin
    if (cfg.start) begin
      grp_base   <= cfg.base;
      line_base  <= cfg.base;
      chunk_base <= cfg.base;
      cur_addr   <= cfg.base;
    end else if (grp_done) begin
      grp_base   <= grp_base + grp_step;
      line_base  <= grp_base + grp_step;
      chunk_base <= grp_base + grp_step;
      cur_addr   <= grp_base + grp_step;
    end else if (row_done) begin
      line_base  <= line_base + rbk_addr_t'(cfg.line_stride);
      chunk_base <= line_base + rbk_addr_t'(cfg.line_stride);
      cur_addr   <= line_base + rbk_addr_t'(cfg.line_stride);
    end else if (plane_end) begin
      chunk_base <= chunk_base + chunk_step;
      cur_addr   <= chunk_base + chunk_step;
    end else if (acc) begin
      // next plane of the same chunk
      cur_addr <= cur_addr + rbk_addr_t'(cfg.planar_stride);
    end
  end

  ////////////////////
  // request level
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      pend      <= 1'b0;
      done_hold <= 1'b0;
    end else begin
      if (all_done | done_hold | dp2reg_done | ~cfg.run) begin
        pend <= 1'b0;
      end else if (cfg.start) begin
        pend <= 1'b1;
      end
      if (dp2reg_done) begin
        done_hold <= 1'b0;
      end else if (all_done) begin
        done_hold <= 1'b1;
      end
    end
  end

  assign req_vld  = pend & buf_rdy;
  assign req_addr = cur_addr;
  assign req_size = rbk_size_t'(size_col);
  assign req_last = plane_last & chunk_last & line_last & grp_last;

  // one buffer command per packed burst or per planar chunk
  assign rf_cmd_vld = acc & (~cfg.planar | (plane_cnt == '0));
  assign rf_cmd.row = cfg.planar ? planes_m1 : 5'd0;
  assign rf_cmd.col = size_col;

  a_req_stable : assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (req_vld && !req_rdy) |=> $stable(req_addr) && $stable(req_size)
  ) else $error("request changed while stalled");

endmodule

// ==== logic/rbk_rd_perf_cnt.sv ====
/*
 * read activity counter for the performance registers, captured
 * into the consumer-selected result register at the end of each run
 */
`timescale 1ns/100ps
`include "rbk_cfg.svh"

module rbk_rd_perf_cnt (
  input  logic nvdla_core_clk,
  input  logic nvdla_core_rstn,
  input  logic perf_en,
  input  logic consumer,
  input  logic rd_req_vld,
  input  logic rd_done,
  output logic [`RBK_PERF_W-1:0] d0_stall_cnt,
  output logic [`RBK_PERF_W-1:0] d1_stall_cnt
);

  logic [`RBK_PERF_W-1:0] cnt;
  logic [`RBK_PERF_W-1:0] cnt_nxt;

  // includes the final accept cycle
  assign cnt_nxt = cnt + `RBK_PERF_W'(perf_en & rd_req_vld);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cnt          <= '0;
      d0_stall_cnt <= '0;
      d1_stall_cnt <= '0;
    end else begin
      if (rd_done) begin
        cnt <= '0;
      end else if (perf_en) begin
        cnt <= cnt_nxt;
      end
      if (rd_done & ~consumer) begin
        d0_stall_cnt <= cnt_nxt;
      end
      if (rd_done & consumer) begin
        d1_stall_cnt <= cnt_nxt;
      end
    end
  end

endmodule

// ==== logic/rbk_seq_gen.sv ====
/*
 * reshape request sequence generator, split and merge modes.
 * drives the read DMA, the write DMA and both buffer command ports
 */
`timescale 1ns/100ps
`include "rbk_cfg.svh"

module rbk_seq_gen (
  input  logic nvdla_core_clk,
  input  logic nvdla_core_rstn,
  input  logic dma_wr_cmd_rdy,
  input  logic dp2reg_consumer,
  input  logic dp2reg_done,
  input  logic rd_req_rdy,
  input  logic [31:0] reg2dp_dain_addr_high,
  input  logic [26:0] reg2dp_dain_addr_low,
  input  logic [26:0] reg2dp_dain_line_stride,
  input  logic [26:0] reg2dp_dain_planar_stride,
  input  logic [26:0] reg2dp_dain_surf_stride,
  input  logic [31:0] reg2dp_daout_addr_high,
  input  logic [26:0] reg2dp_daout_addr_low,
  input  logic [26:0] reg2dp_daout_line_stride,
  input  logic [26:0] reg2dp_daout_planar_stride,
  input  logic [26:0] reg2dp_daout_surf_stride,
  input  logic [12:0] reg2dp_datain_channel,
  input  logic [12:0] reg2dp_datain_height,
  input  logic reg2dp_datain_ram_type,
  input  logic [12:0] reg2dp_datain_width,
  input  logic [12:0] reg2dp_dataout_channel,
  input  logic [1:0] reg2dp_in_precision,
  input  logic reg2dp_op_en,
  input  logic reg2dp_perf_en,
  input  logic [1:0] reg2dp_rubik_mode,
  input  logic rf_rd_cmd_rdy,
  input  logic rf_wr_cmd_rdy,
  output logic [77:0] dma_wr_cmd_pd,
  output logic dma_wr_cmd_vld,
  output logic [31:0] dp2reg_d0_rd_stall_cnt,
  output logic [31:0] dp2reg_d1_rd_stall_cnt,
  output logic [78:0] rd_req_pd,
  output logic rd_req_type,
  output logic rd_req_vld,
  output logic [11:0] rf_rd_cmd_pd,
  output logic rf_rd_cmd_vld,
  output logic [10:0] rf_wr_cmd_pd,
  output logic rf_wr_cmd_vld
);
  import rbk_geom_pkg::*;
  import rbk_cmd_pkg::*;

  rbk_walk_cfg_if rd_cfg ();
  rbk_walk_cfg_if wr_cfg ();

  rbk_addr_t rd_addr;
  rbk_addr_t wr_addr;
  rbk_size_t rd_size;
  rbk_size_t wr_size;
  logic rd_last;
  logic wr_last;
  rbk_rf_cmd_t wr_buf_cmd;
  rbk_rf_cmd_t rd_buf_cmd;
  rbk_rd_pd_t rd_pd;
  rbk_wr_pd_t wr_pd;

  rbk_launch u_launch (
    .nvdla_core_clk      (nvdla_core_clk),
    .nvdla_core_rstn     (nvdla_core_rstn),
    .op_en               (reg2dp_op_en),
    .dp2reg_done         (dp2reg_done),
    .mode                (rbk_mode_e'(reg2dp_rubik_mode)),
    .precision           (rbk_prec_e'(reg2dp_in_precision)),
    .dain_addr_high      (reg2dp_dain_addr_high),
    .dain_addr_low       (reg2dp_dain_addr_low),
    .dain_line_stride    (reg2dp_dain_line_stride),
    .dain_planar_stride  (reg2dp_dain_planar_stride),
    .dain_surf_stride    (reg2dp_dain_surf_stride),
    .datain_width        (reg2dp_datain_width),
    .datain_height       (reg2dp_datain_height),
    .datain_channel      (reg2dp_datain_channel),
    .daout_addr_high     (reg2dp_daout_addr_high),
    .daout_addr_low      (reg2dp_daout_addr_low),
    .daout_line_stride   (reg2dp_daout_line_stride),
    .daout_planar_stride (reg2dp_daout_planar_stride),
    .daout_surf_stride   (reg2dp_daout_surf_stride),
    .dataout_channel     (reg2dp_dataout_channel),
    .rd_cfg              (rd_cfg),
    .wr_cfg              (wr_cfg)
  );

  // read requests fill the buffer, so gated by its write port
  rbk_addr_walker u_rd_walk (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg             (rd_cfg),
    .dp2reg_done     (dp2reg_done),
    .buf_rdy         (rf_wr_cmd_rdy),
    .req_rdy         (rd_req_rdy),
    .req_vld         (rd_req_vld),
    .req_addr        (rd_addr),
    .req_size        (rd_size),
    .req_last        (rd_last),
    .rf_cmd_vld      (rf_wr_cmd_vld),
    .rf_cmd          (wr_buf_cmd)
  );

  rbk_addr_walker u_wr_walk (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg             (wr_cfg),
    .dp2reg_done     (dp2reg_done),
    .buf_rdy         (rf_rd_cmd_rdy),
    .req_rdy         (dma_wr_cmd_rdy),
    .req_vld         (dma_wr_cmd_vld),
    .req_addr        (wr_addr),
    .req_size        (wr_size),
    .req_last        (wr_last),
    .rf_cmd_vld      (rf_rd_cmd_vld),
    .rf_cmd          (rd_buf_cmd)
  );

  rbk_rd_perf_cnt u_perf (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .perf_en         (reg2dp_perf_en),
    .consumer        (dp2reg_consumer),
    .rd_req_vld      (rd_req_vld),
    .rd_done         (rd_req_vld & rd_req_rdy & rd_last),
    .d0_stall_cnt    (dp2reg_d0_rd_stall_cnt),
    .d1_stall_cnt    (dp2reg_d1_rd_stall_cnt)
  );

  ////////////////////
  // payload packing, byte addresses
  assign rd_pd.size = {2'b00, rd_size};
  assign rd_pd.addr = {rd_addr, {`RBK_ATOM_SHIFT{1'b0}}};
  assign wr_pd.done = dma_wr_cmd_vld & wr_last;
  assign wr_pd.size = wr_size;
  assign wr_pd.addr = {wr_addr, {`RBK_ATOM_SHIFT{1'b0}}};

  assign rd_req_pd     = rd_pd;
  assign dma_wr_cmd_pd = wr_pd;
  assign rd_req_type   = reg2dp_datain_ram_type;
  assign rf_wr_cmd_pd  = wr_buf_cmd;
  // read command port keeps a spare top bit
  assign rf_rd_cmd_pd  = {1'b0, rd_buf_cmd};

endmodule

// ==== verif/tb_rbk_seq_gen.sv ====
/*
 * directed testbench for the reshape request generator. builds the
 * expected request and buffer command streams from the address rules
 * and compares them with what the DUT issues, in order
 */
`timescale 1ns/100ps

module tb_rbk_seq_gen;

  localparam logic [1:0] SPLIT = 2'd1;
  localparam logic [1:0] MERGE = 2'd2;
  localparam logic [1:0] INT8 = 2'd0;
  localparam logic [1:0] INT16 = 2'd1;
  // 88 + 252 + 88 + 78 + 70 + 68 requests over all runs
  localparam int TOTAL_REQS = 644;
  localparam int WATCHDOG_CYC = TOTAL_REQS * 8 + 1000;

  logic nvdla_core_clk = 1'b0;
  logic nvdla_core_rstn;
  logic dma_wr_cmd_rdy = 1'b1;
  logic rd_req_rdy = 1'b1;
  logic rf_rd_cmd_rdy = 1'b1;
  logic rf_wr_cmd_rdy = 1'b1;
  logic dp2reg_consumer;
  logic dp2reg_done;
  logic [31:0] reg2dp_dain_addr_high;
  logic [26:0] reg2dp_dain_addr_low;
  logic [26:0] reg2dp_dain_line_stride;
  logic [26:0] reg2dp_dain_planar_stride;
  logic [26:0] reg2dp_dain_surf_stride;
  logic [31:0] reg2dp_daout_addr_high;
  logic [26:0] reg2dp_daout_addr_low;
  logic [26:0] reg2dp_daout_line_stride;
  logic [26:0] reg2dp_daout_planar_stride;
  logic [26:0] reg2dp_daout_surf_stride;
  logic [12:0] reg2dp_datain_channel;
  logic [12:0] reg2dp_datain_height;
  logic reg2dp_datain_ram_type;
  logic [12:0] reg2dp_datain_width;
  logic [12:0] reg2dp_dataout_channel;
  logic [1:0] reg2dp_in_precision;
  logic reg2dp_op_en;
  logic reg2dp_perf_en;
  logic [1:0] reg2dp_rubik_mode;
  logic [77:0] dma_wr_cmd_pd;
  logic dma_wr_cmd_vld;
  logic [31:0] dp2reg_d0_rd_stall_cnt;
  logic [31:0] dp2reg_d1_rd_stall_cnt;
  logic [78:0] rd_req_pd;
  logic rd_req_type;
  logic rd_req_vld;
  logic [11:0] rf_rd_cmd_pd;
  logic rf_rd_cmd_vld;
  logic [10:0] rf_wr_cmd_pd;
  logic rf_wr_cmd_vld;

  // expected streams from the model
  logic [78:0] exp_rd[$];
  logic [10:0] exp_rd_rf[$];
  logic [77:0] exp_wr[$];
  logic [10:0] exp_wr_rf[$];
  // accepted traffic from the monitor
  logic [78:0] got_rd[$];
  logic [10:0] got_rd_rf[$];
  logic [77:0] got_wr[$];
  logic [10:0] got_wr_rf[$];
  int vld_count = 0;
  int gate_viol = 0;
  int errors = 0;
  int rd0;
  int wr0;
  int rdrf0;
  int wrrf0;
  logic stall_on = 1'b0;

  rbk_seq_gen u_rbk_seq_gen (.*);

  always #50 nvdla_core_clk = ~nvdla_core_clk;

  // random ready stalls when enabled
  always @(posedge nvdla_core_clk) begin
    rd_req_rdy     <= stall_on ? (($urandom() % 4) != 0) : 1'b1;
    dma_wr_cmd_rdy <= stall_on ? (($urandom() % 4) != 0) : 1'b1;
    rf_wr_cmd_rdy  <= stall_on ? (($urandom() % 4) != 0) : 1'b1;
    rf_rd_cmd_rdy  <= stall_on ? (($urandom() % 4) != 0) : 1'b1;
  end

  ////////////////////
  // monitor samples mid cycle
  always @(negedge nvdla_core_clk) begin
    if (nvdla_core_rstn) begin
      if (rd_req_vld) begin
        vld_count++;
      end
      if (rd_req_vld && !rf_wr_cmd_rdy) begin
        gate_viol++;
        $display("read request valid while rf_wr_cmd_rdy is low at %0t", $time);
      end
      if (dma_wr_cmd_vld && !rf_rd_cmd_rdy) begin
        gate_viol++;
        $display("write request valid while rf_rd_cmd_rdy is low at %0t", $time);
      end
      if (rd_req_vld && rd_req_rdy) begin
        got_rd.push_back(rd_req_pd);
      end
      if (rf_wr_cmd_vld) begin
        got_rd_rf.push_back(rf_wr_cmd_pd);
      end
      if (dma_wr_cmd_vld && dma_wr_cmd_rdy) begin
        got_wr.push_back(dma_wr_cmd_pd);
      end
      if (rf_rd_cmd_vld) begin
        got_wr_rf.push_back(rf_rd_cmd_pd[10:0]);
        compare_val("rf_rd_cmd_pd spare bit", 80'(rf_rd_cmd_pd[11]), 80'(1'b0));
      end
    end
  end

  task automatic compare_val(input string name, input logic [79:0] got, input logic [79:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  ////////////////////
  // reference model of one stream
  task automatic model_side(input bit is_rd, input bit planar, input bit int8,
                            input logic [58:0] base, input logic [26:0] line_s,
                            input logic [26:0] surf_s, input logic [26:0] pln_s,
                            input int w, input int h, input int c);
    int grp_sz;
    int step;
    int n_grp;
    int n_chk;
    int planes;
    int elems;
    int size;
    int total;
    int idx;
    logic [58:0] addr;
    grp_sz = int8 ? 32 : 16;
    step = int8 ? 2 : 4;
    n_grp = (c + grp_sz - 1) / grp_sz;
    n_chk = (w + 63) / 64;
    total = planar ? h * n_chk * c : n_grp * h * n_chk;
    idx = 0;
    for (int g = 0; g < n_grp; g++) begin
      for (int l = 0; l < h; l++) begin
        for (int k = 0; k < n_chk; k++) begin
          elems = (w - 64 * k < 64) ? w - 64 * k : 64;
          planes = (c - g * grp_sz < grp_sz) ? c - g * grp_sz : grp_sz;
          if (!planar) begin
            planes = 1;
          end
          // planar bursts carry one plane of the chunk
          size = planar ? (elems * (int8 ? 1 : 2) + 31) / 32 - 1 : elems - 1;
          for (int p = 0; p < planes; p++) begin
            if (planar) begin
              addr = base + 59'(g * grp_sz + p) * 59'(pln_s) + 59'(l) * 59'(line_s) +
                     59'(k * step);
            end else begin
              addr = base + 59'(g) * 59'(surf_s) + 59'(l) * 59'(line_s) + 59'(64 * k);
            end
            if (is_rd) begin
              exp_rd.push_back({2'b00, 13'(size), addr, 5'b00000});
            end else begin
              exp_wr.push_back({idx == total - 1, 13'(size), addr, 5'b00000});
            end
            if (!planar || p == 0) begin
              if (is_rd) begin
                exp_rd_rf.push_back({5'(planar ? planes - 1 : 0), 6'(size)});
              end else begin
                exp_wr_rf.push_back({5'(planar ? planes - 1 : 0), 6'(size)});
              end
            end
            idx++;
          end
        end
      end
    end
  endtask

  task automatic setup_op(input logic [1:0] mode, input logic [1:0] prec, input int w,
                          input int h, input int cin, input int cout);
    logic [31:0] in_hi;
    logic [31:0] out_hi;
    logic [26:0] in_lo;
    logic [26:0] out_lo;
    logic [26:0] in_line;
    logic [26:0] out_line;
    logic [26:0] in_surf;
    logic [26:0] out_surf;
    logic [26:0] in_pln;
    logic [26:0] out_pln;
    in_hi = $urandom();
    in_lo = 27'($urandom());
    in_line = 27'($urandom());
    in_surf = 27'($urandom());
    in_pln = 27'($urandom());
    out_hi = $urandom();
    out_lo = 27'($urandom());
    out_line = 27'($urandom());
    out_surf = 27'($urandom());
    out_pln = 27'($urandom());
    @(posedge nvdla_core_clk);
    reg2dp_rubik_mode <= mode;
    reg2dp_in_precision <= prec;
    reg2dp_datain_width <= 13'(w - 1);
    reg2dp_datain_height <= 13'(h - 1);
    reg2dp_datain_channel <= 13'(cin - 1);
    reg2dp_dataout_channel <= 13'(cout - 1);
    reg2dp_dain_addr_high <= in_hi;
    reg2dp_dain_addr_low <= in_lo;
    reg2dp_dain_line_stride <= in_line;
    reg2dp_dain_surf_stride <= in_surf;
    reg2dp_dain_planar_stride <= in_pln;
    reg2dp_daout_addr_high <= out_hi;
    reg2dp_daout_addr_low <= out_lo;
    reg2dp_daout_line_stride <= out_line;
    reg2dp_daout_surf_stride <= out_surf;
    reg2dp_daout_planar_stride <= out_pln;
    exp_rd.delete();
    exp_rd_rf.delete();
    exp_wr.delete();
    exp_wr_rf.delete();
    // merge reads planar, split writes planar
    model_side(1'b1, mode == MERGE, prec == INT8, {in_hi, in_lo}, in_line, in_surf, in_pln,
               w, h, cin);
    model_side(1'b0, mode == SPLIT, prec == INT8, {out_hi, out_lo}, out_line, out_surf,
               out_pln, w, h, cout);
  endtask

  // one operation and a compare of all four streams
  task automatic run_op(output int vld_cyc);
    int n;
    int limit;
    int vld0;
    rd0 = got_rd.size();
    wr0 = got_wr.size();
    rdrf0 = got_rd_rf.size();
    wrrf0 = got_wr_rf.size();
    vld0 = vld_count;
    @(posedge nvdla_core_clk);
    reg2dp_op_en <= 1'b1;
    @(posedge nvdla_core_clk);
    reg2dp_op_en <= 1'b0;
    n = 0;
    while (!(rd_req_vld || dma_wr_cmd_vld) && n < 20) begin
      @(negedge nvdla_core_clk);
      n++;
    end
    if (n >= 20) begin
      errors++;
      $display("no request valid within 20 cycles of op_en at %0t", $time);
    end
    n = 0;
    limit = 20 * (exp_rd.size() + exp_wr.size()) + 20;
    while ((got_rd.size() - rd0 < exp_rd.size() || got_wr.size() - wr0 < exp_wr.size()) &&
           n < limit) begin
      @(negedge nvdla_core_clk);
      n++;
    end
    if (n >= limit) begin
      errors++;
      $display("request streams incomplete after %0d cycles at %0t", limit, $time);
    end
    repeat (4) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    vld_cyc = vld_count - vld0;
    compare_val("read request count", 80'(got_rd.size() - rd0), 80'(exp_rd.size()));
    compare_val("write request count", 80'(got_wr.size() - wr0), 80'(exp_wr.size()));
    compare_val("rf_wr_cmd count", 80'(got_rd_rf.size() - rdrf0), 80'(exp_rd_rf.size()));
    compare_val("rf_rd_cmd count", 80'(got_wr_rf.size() - wrrf0), 80'(exp_wr_rf.size()));
    for (int i = 0; i < exp_rd.size() && rd0 + i < got_rd.size(); i++) begin
      compare_val("rd_req_pd", 80'(got_rd[rd0 + i]), 80'(exp_rd[i]));
    end
    for (int i = 0; i < exp_wr.size() && wr0 + i < got_wr.size(); i++) begin
      compare_val("dma_wr_cmd_pd", 80'(got_wr[wr0 + i]), 80'(exp_wr[i]));
    end
    for (int i = 0; i < exp_rd_rf.size() && rdrf0 + i < got_rd_rf.size(); i++) begin
      compare_val("rf_wr_cmd_pd", 80'(got_rd_rf[rdrf0 + i]), 80'(exp_rd_rf[i]));
    end
    for (int i = 0; i < exp_wr_rf.size() && wrrf0 + i < got_wr_rf.size(); i++) begin
      compare_val("rf_rd_cmd_pd", 80'(got_wr_rf[wrrf0 + i]), 80'(exp_wr_rf[i]));
    end
  endtask

  task automatic pulse_done();
    @(posedge nvdla_core_clk);
    dp2reg_done <= 1'b1;
    @(posedge nvdla_core_clk);
    dp2reg_done <= 1'b0;
  endtask

  // cycles with any valid or strobe high
  task automatic count_busy(input int n, output int busy);
    busy = 0;
    repeat (n) begin
      @(negedge nvdla_core_clk);
      if (rd_req_vld || dma_wr_cmd_vld || rf_wr_cmd_vld || rf_rd_cmd_vld) begin
        busy++;
      end
    end
  endtask

  ////////////////////
  // directed tests
  task automatic split_int16_streams();
    int cyc;
    setup_op(SPLIT, INT16, 100, 2, 20, 20);
    reg2dp_datain_ram_type <= 1'b1;
    run_op(cyc);
    compare_val("rd_req_type", 80'(rd_req_type), 80'(1'b1));
    pulse_done();
  endtask

  task automatic merge_int8_streams();
    int cyc;
    setup_op(MERGE, INT8, 70, 3, 40, 40);
    run_op(cyc);
    pulse_done();
  endtask

  task automatic stalled_split_streams();
    int cyc;
    stall_on <= 1'b1;
    setup_op(SPLIT, INT16, 100, 2, 20, 20);
    run_op(cyc);
    pulse_done();
    stall_on <= 1'b0;
  endtask

  task automatic buffer_cmd_rules();
    int cyc;
    stall_on <= 1'b1;
    setup_op(MERGE, INT16, 130, 1, 24, 24);
    run_op(cyc);
    // planar read side has 2 groups x 1 line x 3 chunks
    compare_val("rf_wr_cmd strobes", 80'(got_rd_rf.size() - rdrf0), 80'(6));
    // packed write side has one strobe for each of its 6 bursts
    compare_val("rf_rd_cmd strobes", 80'(got_wr_rf.size() - wrrf0), 80'(6));
    pulse_done();
    stall_on <= 1'b0;
  endtask

  task automatic done_bit_and_rearm();
    int cyc;
    int busy;
    int n_done;
    setup_op(SPLIT, INT8, 40, 1, 33, 33);
    run_op(cyc);
    n_done = 0;
    for (int i = wr0; i < got_wr.size(); i++) begin
      if (got_wr[i][77]) begin
        n_done++;
      end
    end
    compare_val("done bit count", 80'(n_done), 80'(1));
    compare_val("final done bit", 80'(got_wr[got_wr.size() - 1][77]), 80'(1'b1));
    count_busy(10, busy);
    compare_val("busy cycles after done", 80'(busy), 80'(0));
    // op_en without dp2reg_done must not restart
    @(posedge nvdla_core_clk);
    reg2dp_op_en <= 1'b1;
    @(posedge nvdla_core_clk);
    reg2dp_op_en <= 1'b0;
    count_busy(10, busy);
    compare_val("busy cycles before dp2reg_done", 80'(busy), 80'(0));
    pulse_done();
    count_busy(4, busy);
    compare_val("busy cycles after dp2reg_done", 80'(busy), 80'(0));
    run_op(cyc);
    pulse_done();
  endtask

  task automatic perf_capture();
    int cyc0;
    int cyc1;
    stall_on <= 1'b1;
    setup_op(MERGE, INT16, 20, 2, 16, 16);
    reg2dp_perf_en <= 1'b1;
    dp2reg_consumer <= 1'b0;
    run_op(cyc0);
    compare_val("dp2reg_d0_rd_stall_cnt", 80'(dp2reg_d0_rd_stall_cnt), 80'(cyc0));
    pulse_done();
    setup_op(MERGE, INT16, 20, 2, 16, 16);
    dp2reg_consumer <= 1'b1;
    run_op(cyc1);
    compare_val("dp2reg_d1_rd_stall_cnt", 80'(dp2reg_d1_rd_stall_cnt), 80'(cyc1));
    compare_val("dp2reg_d0_rd_stall_cnt", 80'(dp2reg_d0_rd_stall_cnt), 80'(cyc0));
    pulse_done();
    stall_on <= 1'b0;
  endtask

  initial begin
    int busy;
    void'($urandom(32'hfbc0));
    nvdla_core_rstn = 1'b0;
    dp2reg_consumer = 1'b0;
    dp2reg_done = 1'b0;
    reg2dp_dain_addr_high = '0;
    reg2dp_dain_addr_low = '0;
    reg2dp_dain_line_stride = '0;
    reg2dp_dain_planar_stride = '0;
    reg2dp_dain_surf_stride = '0;
    reg2dp_daout_addr_high = '0;
    reg2dp_daout_addr_low = '0;
    reg2dp_daout_line_stride = '0;
    reg2dp_daout_planar_stride = '0;
    reg2dp_daout_surf_stride = '0;
    reg2dp_datain_channel = '0;
    reg2dp_datain_height = '0;
    reg2dp_datain_ram_type = 1'b0;
    reg2dp_datain_width = '0;
    reg2dp_dataout_channel = '0;
    reg2dp_in_precision = INT8;
    reg2dp_op_en = 1'b0;
    reg2dp_perf_en = 1'b0;
    reg2dp_rubik_mode = SPLIT;
    repeat (16) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
    count_busy(4, busy);
    compare_val("busy cycles after reset", 80'(busy), 80'(0));
    split_int16_streams();
    merge_int8_streams();
    stalled_split_streams();
    buffer_cmd_rules();
    done_bit_and_rearm();
    perf_capture();
    $display("check failures: %0d, ready gating violations: %0d", errors, gate_viol);
    if (errors == 0 && gate_viol == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_CYC * 100);
    $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYC);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+logic
logic/rbk_geom_pkg.sv
logic/rbk_cmd_pkg.sv
logic/rbk_walk_cfg_if.sv
logic/rbk_launch.sv
logic/rbk_addr_walker.sv
logic/rbk_rd_perf_cnt.sv
logic/rbk_seq_gen.sv
verif/tb_rbk_seq_gen.sv

// ==== Makefile ====
TOP = tb_rbk_seq_gen

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module rbk_seq_gen

obj_dir/V$(TOP): flist.f logic/*.sv logic/*.svh verif/*.sv
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir
